// ==== design/mem_params.svh ====
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// processor side address and data
`define ADDR_W 32
`define WORD_W 32

// ram is byte wide
`define BYTE_W 8

// bytes per word
`define WORD_BYTES (`WORD_W / `BYTE_W)

`endif

// ==== design/memPkg.sv ====
`include "mem_params.svh"

package memPkg;

    typedef logic [`ADDR_W-1:0] addr_t;
    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`BYTE_W-1:0] byte_t;

    // access length in bytes, only 1, 2 or 4
    typedef logic [2:0] byteLen_t;

    // byte position inside a word
    typedef logic [1:0] lane_t;

    typedef enum logic [1:0] {
        kFetch,
        kLoad,
        kStore
    } accessKind_e;

    // one registered request waiting for the sequencer
    typedef struct packed {
        logic        valid;
        accessKind_e kind;
        addr_t       addr;
        byteLen_t    len;
        word_t       wdata;
    } memReq_t;

    // one byte beat, travels alongside the ram address
    typedef struct packed {
        logic        valid;
        accessKind_e kind;
        lane_t       lane;
        logic        last;
    } memBeat_t;

endpackage

// ==== design/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_fetchEn,
    input  memPkg::addr_t    i_fetchAddr,
    input  logic             i_dataEn,
    input  logic             i_dataStore,
    input  memPkg::byteLen_t i_dataLen,
    input  memPkg::addr_t    i_dataAddr,
    input  memPkg::word_t    i_dataWr,
    input  logic             i_take,
    output memPkg::memReq_t  o_req
);
    import memPkg::*;

    logic    fetchTaken;
    logic    dataTaken;
    logic    fetchReady;
    logic    dataReady;
    logic    canLoad;
    memReq_t fetchReq;
    memReq_t dataReq;

    // a source counts again only after its enable went low
    assign fetchReady = i_fetchEn && !fetchTaken;
    assign dataReady  = i_dataEn && !dataTaken;

    assign canLoad = !o_req.valid || i_take;

    always_comb begin
        fetchReq.valid = 1'b1;
        fetchReq.kind  = kFetch;
        fetchReq.addr  = i_fetchAddr;
        fetchReq.len   = 3'd4;
        fetchReq.wdata = '0;
    end

    always_comb begin
        dataReq.valid = 1'b1;
        dataReq.kind  = i_dataStore ? kStore : kLoad;
        dataReq.addr  = i_dataAddr;
        dataReq.len   = i_dataLen;
        dataReq.wdata = i_dataWr;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_req.valid <= 1'b0;
            fetchTaken  <= 1'b0;
            dataTaken   <= 1'b0;
        end else begin
            if (!i_fetchEn) begin
                fetchTaken <= 1'b0;
            end
            if (!i_dataEn) begin
                dataTaken <= 1'b0;
            end

            // data wins over fetch
            if (canLoad) begin
                if (dataReady) begin
                    o_req     <= dataReq;
                    dataTaken <= 1'b1;
                end else if (fetchReady) begin
                    o_req      <= fetchReq;
                    fetchTaken <= 1'b1;
                end else begin
                    o_req.valid <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== design/byteSequencer.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module byteSequencer (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_rdy,
    input  logic             i_ioBufferFull,
    input  memPkg::memReq_t  i_req,
    output logic             o_take,
    output memPkg::memBeat_t o_beat,
    output logic             o_memWe,
    output memPkg::addr_t    o_memAddr,
    output memPkg::byte_t    o_memDt
);
    import memPkg::*;

    memReq_t curReq;
    lane_t   byteCnt;
    memReq_t srcReq;
    lane_t   lastIdx;
    logic    hold;
    logic    issue;
    logic    isLast;

    assign hold = i_ioBufferFull || !i_rdy;

    // a request with beats left has priority over the waiting one
    assign srcReq = curReq.valid ? curReq : i_req;

    assign lastIdx = lane_t'(srcReq.len - 3'd1);
    assign isLast  = (byteCnt == lastIdx);
    assign issue   = srcReq.valid && !hold;

    // first beat of a new request is issued straight from the arbiter
    assign o_take = issue && !curReq.valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            curReq.valid <= 1'b0;
            byteCnt      <= '0;
            o_beat.valid <= 1'b0;
            o_memWe      <= 1'b0;
        end else begin
            o_beat.valid <= issue;
            o_memWe      <= issue && (srcReq.kind == kStore);

            if (issue) begin
                o_beat.kind <= srcReq.kind;
                o_beat.lane <= byteCnt;
                o_beat.last <= isLast;

                if (isLast) begin
                    // next cycle may already start the following request
                    curReq.valid <= 1'b0;
                    byteCnt      <= '0;
                end else begin
                    curReq  <= srcReq;
                    byteCnt <= lane_t'(byteCnt + 2'd1);
                end
            end
        end
    end

    // ram address and write byte
    always_ff @(posedge clk) begin
        if (issue) begin
            o_memAddr <= srcReq.addr + addr_t'(byteCnt);
            o_memDt   <= srcReq.wdata[byteCnt*`BYTE_W +: `BYTE_W];
        end
    end

endmodule

// ==== design/wordAssembler.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module wordAssembler (
    input  logic             clk,
    input  logic             rst,
    input  memPkg::memBeat_t i_beat,
    input  memPkg::byte_t    i_memDt,
    output logic             o_instDone,
    output memPkg::word_t    o_inst,
    output logic             o_dataDone,
    output memPkg::word_t    o_dataRd
);
    import memPkg::*;

    memBeat_t beatQ;
    word_t    wordBuf;
    word_t    nextWord;
    logic     beatEnd;

    // read data shows up one cycle after the beat left the sequencer
    assign beatEnd = beatQ.valid && beatQ.last;

    always_comb begin
        // lane 0 starts a fresh word, so short loads are zero-extended
        nextWord = (beatQ.lane == '0) ? '0 : wordBuf;
        nextWord[beatQ.lane*`BYTE_W +: `BYTE_W] = i_memDt;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beatQ.valid <= 1'b0;
            o_instDone  <= 1'b0;
            o_dataDone  <= 1'b0;
        end else begin
            beatQ      <= i_beat;
            o_instDone <= beatEnd && (beatQ.kind == kFetch);
            o_dataDone <= beatEnd && (beatQ.kind != kFetch);
        end
    end

    always_ff @(posedge clk) begin
        // stores bring no read data
        if (beatQ.valid && beatQ.kind != kStore) begin
            wordBuf <= nextWord;
        end
        if (beatEnd && beatQ.kind == kFetch) begin
            o_inst <= nextWord;
        end
        if (beatEnd && beatQ.kind == kLoad) begin
            o_dataRd <= nextWord;
        end
    end

endmodule

// ==== design/memSubsys.sv ====
`timescale 1ns/1ps

module memSubsys (
    input  logic             clk,
    input  logic             rst,
    input  logic             i_rdy,
    input  logic             i_ioBufferFull,
    input  logic             i_fetchEn,
    input  memPkg::addr_t    i_fetchAddr,
    output logic             o_instDone,
    output memPkg::word_t    o_inst,
    input  logic             i_dataEn,
    input  logic             i_dataStore,
    input  memPkg::byteLen_t i_dataLen,
    input  memPkg::addr_t    i_dataAddr,
    input  memPkg::word_t    i_dataWr,
    output logic             o_dataDone,
    output memPkg::word_t    o_dataRd,
    output logic             o_memWe,
    output memPkg::addr_t    o_memAddr,
    output memPkg::byte_t    o_memDt,
    input  memPkg::byte_t    i_memDt
);
    import memPkg::*;

    memReq_t  req;
    logic     take;
    memBeat_t beat;

    memArbiter u_memArbiter (
        .clk         (clk),
        .rst         (rst),
        .i_fetchEn   (i_fetchEn),
        .i_fetchAddr (i_fetchAddr),
        .i_dataEn    (i_dataEn),
        .i_dataStore (i_dataStore),
        .i_dataLen   (i_dataLen),
        .i_dataAddr  (i_dataAddr),
        .i_dataWr    (i_dataWr),
        .i_take      (take),
        .o_req       (req)
    );

    byteSequencer u_byteSequencer (
        .clk            (clk),
        .rst            (rst),
        .i_rdy          (i_rdy),
        .i_ioBufferFull (i_ioBufferFull),
        .i_req          (req),
        .o_take         (take),
        .o_beat         (beat),
        .o_memWe        (o_memWe),
        .o_memAddr      (o_memAddr),
        .o_memDt        (o_memDt)
    );

    wordAssembler u_wordAssembler (
        .clk        (clk),
        .rst        (rst),
        .i_beat     (beat),
        .i_memDt    (i_memDt),
        .o_instDone (o_instDone),
        .o_inst     (o_inst),
        .o_dataDone (o_dataDone),
        .o_dataRd   (o_dataRd)
    );

endmodule

// ==== tests/memSubsys_asserts.sv ====
`timescale 1ns/1ps

module memSubsysAsserts (
    input logic clk,
    input logic rst,
    input logic i_rdy,
    input logic i_ioBufferFull,
    input logic i_memWe,
    input logic i_instDone,
    input logic i_dataDone
);

    // a held cycle issues no beat, so no write strobe follows it
    holdBlocksWrite: assert property (@(posedge clk) disable iff (rst)
        (i_ioBufferFull || !i_rdy) |=> !i_memWe)
        else $error("write strobe follows a held cycle");

    instDoneSingle: assert property (@(posedge clk) disable iff (rst)
        i_instDone |=> !i_instDone)
        else $error("o_instDone high for two cycles");

    dataDoneSingle: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone)
        else $error("o_dataDone high for two cycles");

    quietAfterReset: assert property (@(posedge clk)
        rst |=> (!i_instDone && !i_dataDone && !i_memWe))
        else $error("done or write strobe high right after reset");

endmodule

bind memSubsys memSubsysAsserts u_memSubsysAsserts (
    .clk            (clk),
    .rst            (rst),
    .i_rdy          (i_rdy),
    .i_ioBufferFull (i_ioBufferFull),
    .i_memWe        (o_memWe),
    .i_instDone     (o_instDone),
    .i_dataDone     (o_dataDone)
);

// ==== tests/memSubsysTb.sv ====
`timescale 1ns/1ps
`include "mem_params.svh"

module memSubsysTb;
    import memPkg::*;

    localparam int kTimeout = 400;

    logic        clk = 1'b0;
    logic        rst;
    logic        i_rdy;
    logic        i_ioBufferFull;
    logic        i_fetchEn;
    addr_t       i_fetchAddr;
    logic        o_instDone;
    word_t       o_inst;
    logic        i_dataEn;
    logic        i_dataStore;
    byteLen_t    i_dataLen;
    addr_t       i_dataAddr;
    word_t       i_dataWr;
    logic        o_dataDone;
    word_t       o_dataRd;
    logic        o_memWe;
    addr_t       o_memAddr;
    byte_t       o_memDt;
    byte_t       i_memDt;
    byte_t       ram [0:65535];
    byte_t       refMem [0:65535];
    logic        holdMode;
    int unsigned seedInit;

    memSubsys i_memSubsys (.*);

    always #4 clk = ~clk;

    function automatic byte_t fillByte(logic [15:0] a);
        return a[7:0] ^ {a[10:8], a[15:11]} ^ 8'ha5;
    endfunction

    // byte ram, read data one cycle after the address
    initial begin
        i_memDt = '0;
        for (int i = 0; i < 65536; i++) begin
            ram[i[15:0]] = fillByte(i[15:0]);
        end
        forever begin
            @(posedge clk);
            i_memDt <= ram[o_memAddr[15:0]];
            if (o_memWe) begin
                ram[o_memAddr[15:0]] = o_memDt;
            end
        end
    end

    // random stretches of a full io buffer or a chip that is not ready
    initial begin
        int stretch;
        int holdKind;
        stretch = 0;
        holdKind = 0;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        forever begin
            @(negedge clk);
            if (!holdMode || stretch == 0) begin
                i_rdy = 1'b1;
                i_ioBufferFull = 1'b0;
                if (holdMode) begin
                    stretch = $urandom_range(1, 4);
                    holdKind = $urandom_range(0, 2);
                end
            end else begin
                stretch--;
                i_ioBufferFull = (holdKind == 1);
                i_rdy = (holdKind != 2);
            end
        end
    end

    task automatic failRun(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            failRun($sformatf("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp));
        end
    endtask

    function automatic logic [15:0] memIdx(addr_t a, int k);
        return a[15:0] + 16'(k);
    endfunction

    // little-endian bytes from the reference, upper bytes zero
    function automatic word_t expectRead(addr_t a, byteLen_t len);
        word_t w;
        w = '0;
        for (int k = 0; k < int'(len); k++) begin
            w[k*`BYTE_W +: `BYTE_W] = refMem[memIdx(a, k)];
        end
        return w;
    endfunction

    function automatic addr_t randAddr();
        return addr_t'($urandom_range(8, 65520));
    endfunction

    function automatic byteLen_t randLen();
        case ($urandom_range(0, 2))
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // enable drops on the cycle after the done pulse
    task automatic waitDone(input logic forData, output word_t result);
        int n;
        logic seen;
        n = 0;
        seen = 1'b0;
        result = '0;
        while (!seen && n < kTimeout) begin
            @(negedge clk);
            n++;
            if (forData && o_dataDone) begin
                result = o_dataRd;
                i_dataEn = 1'b0;
                seen = 1'b1;
            end else if (!forData && o_instDone) begin
                result = o_inst;
                i_fetchEn = 1'b0;
                seen = 1'b1;
            end
        end
        if (!seen) begin
            failRun(forData ? "timed out waiting for the data done pulse"
                            : "timed out waiting for the fetch done pulse");
        end
    endtask

    task automatic fetchWord(addr_t a);
        word_t got;
        @(negedge clk);
        i_fetchAddr = a;
        i_fetchEn = 1'b1;
        waitDone(1'b0, got);
        checkEq("o_inst", got, expectRead(a, 3'd4));
    endtask

    task automatic loadData(addr_t a, byteLen_t len);
        word_t got;
        @(negedge clk);
        i_dataAddr = a;
        i_dataLen = len;
        i_dataStore = 1'b0;
        i_dataEn = 1'b1;
        waitDone(1'b1, got);
        checkEq("o_dataRd", got, expectRead(a, len));
    endtask

    task automatic storeData(addr_t a, byteLen_t len, word_t wd);
        word_t ignored;
        @(negedge clk);
        i_dataAddr = a;
        i_dataLen = len;
        i_dataWr = wd;
        i_dataStore = 1'b1;
        i_dataEn = 1'b1;
        waitDone(1'b1, ignored);
        for (int k = 0; k < int'(len); k++) begin
            refMem[memIdx(a, k)] = wd[k*`BYTE_W +: `BYTE_W];
        end
    endtask

    task automatic compareRam();
        for (int i = 0; i < 65536; i++) begin
            if (ram[i[15:0]] !== refMem[i[15:0]]) begin
                checkEq($sformatf("ram[0x%04h]", i), {24'd0, ram[i[15:0]]},
                        {24'd0, refMem[i[15:0]]});
            end
        end
    endtask

    task automatic idleAfterReset();
        repeat (10) begin
            @(negedge clk);
            checkEq("o_instDone", {31'd0, o_instDone}, 32'd0);
            checkEq("o_dataDone", {31'd0, o_dataDone}, 32'd0);
            checkEq("o_memWe", {31'd0, o_memWe}, 32'd0);
        end
    endtask

    task automatic storeAndReadBack();
        addr_t    a;
        byteLen_t len;
        for (int r = 0; r < 6; r++) begin
            // each store length in turn
            case (r % 3)
                0: len = 3'd1;
                1: len = 3'd2;
                default: len = 3'd4;
            endcase
            a = randAddr();
            storeData(a, len, word_t'($urandom));
            loadData(a - 32'd4, 3'd4);
            loadData(a, 3'd4);
            loadData(a + 32'd4, 3'd4);
        end
        compareRam();
    endtask

    // both enables in one cycle, data must finish first
    task automatic dataBeforeFetch(addr_t fa, addr_t da, byteLen_t len);
        int n;
        int instAt;
        int dataAt;
        n = 0;
        instAt = 0;
        dataAt = 0;
        @(negedge clk);
        i_fetchAddr = fa;
        i_dataAddr = da;
        i_dataLen = len;
        i_dataStore = 1'b0;
        i_fetchEn = 1'b1;
        i_dataEn = 1'b1;
        while ((instAt == 0 || dataAt == 0) && n < kTimeout) begin
            @(negedge clk);
            n++;
            if (o_dataDone && dataAt == 0) begin
                dataAt = n;
                i_dataEn = 1'b0;
                checkEq("o_dataRd", o_dataRd, expectRead(da, len));
            end
            if (o_instDone && instAt == 0) begin
                instAt = n;
                i_fetchEn = 1'b0;
                checkEq("o_inst", o_inst, expectRead(fa, 3'd4));
            end
        end
        if (instAt == 0 || dataAt == 0) begin
            failRun("timed out waiting for both done pulses");
        end
        if (dataAt >= instAt) begin
            failRun("the data request did not finish before the fetch");
        end
    endtask

    task automatic trafficUnderHold();
        holdMode = 1'b1;
        repeat (24) begin
            case ($urandom_range(0, 2))
                0: fetchWord(randAddr());
                1: loadData(randAddr(), randLen());
                default: storeData(randAddr(), randLen(), word_t'($urandom));
            endcase
        end
        holdMode = 1'b0;
        compareRam();
    endtask

    initial begin
        seedInit = $urandom(32'hed7c235d);
        holdMode = 1'b0;
        rst = 1'b1;
        i_fetchEn = 1'b0;
        i_fetchAddr = '0;
        i_dataEn = 1'b0;
        i_dataStore = 1'b0;
        i_dataLen = 3'd4;
        i_dataAddr = '0;
        i_dataWr = '0;
        for (int i = 0; i < 65536; i++) begin
            refMem[i[15:0]] = fillByte(i[15:0]);
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;

        idleAfterReset();
        repeat (8) fetchWord(randAddr());
        repeat (4) loadData(randAddr(), 3'd1);
        repeat (4) loadData(randAddr(), 3'd2);
        repeat (4) loadData(randAddr(), 3'd4);
        storeAndReadBack();
        repeat (4) dataBeforeFetch(randAddr(), randAddr(), randLen());
        trafficUnderHold();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+design
design/memPkg.sv
design/memArbiter.sv
design/byteSequencer.sv
design/wordAssembler.sv
design/memSubsys.sv
tests/memSubsys_asserts.sv
tests/memSubsysTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f src.f --top-module memSubsysTb -Mdir obj_dir &&
./obj_dir/VmemSubsysTb || exit 1
